// ==== hdl/core_pkg.sv ====
package core_pkg;

  parameter int DATA_WIDTH     = 32;
  parameter int REG_ADDR_WIDTH = 5;
  parameter int NUM_REGS       = 32;

  // Instruction word layout
  parameter int OPCODE_MSB = 31;
  parameter int OPCODE_LSB = 28;
  parameter int RD_MSB     = 27;
  parameter int RD_LSB     = 23;
  parameter int RS_MSB     = 22;
  parameter int RS_LSB     = 18;
  parameter int RT_MSB     = 17;
  parameter int RT_LSB     = 13;
  parameter int IMM_WIDTH  = 16;

  // Unlisted encodings execute as OP_ADD
  typedef enum logic [3:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_OR  = 4'd3,
    OP_XOR = 4'd4,
    OP_SLT = 4'd5,
    OP_MUL = 4'd6,
    OP_LI  = 4'd7
  } op_t;

endpackage

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      inst_valid,
  input  logic [OPCODE_MSB:0]       inst_word,
  input  logic                      iq_full,
  input  logic                      rob_full,
  output logic                      stall,
  output logic                      alloc,
  output op_t                       dec_op,
  output logic [REG_ADDR_WIDTH-1:0] dec_rd,
  output logic [REG_ADDR_WIDTH-1:0] dec_rs,
  output logic [REG_ADDR_WIDTH-1:0] dec_rt,
  output logic [IMM_WIDTH-1:0]      dec_imm
);

  logic                held_valid;
  logic [OPCODE_MSB:0] held_word;
  logic                accept;

  // Held entry moves on once both queue and reorder buffer have room
  assign alloc  = held_valid && !iq_full && !rob_full;
  assign stall  = held_valid && !alloc;
  assign accept = inst_valid && !stall;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
    end else if (accept) begin
      held_valid <= 1'b1;
    end else if (alloc) begin
      held_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      held_word <= inst_word;
    end
  end

  assign dec_op  = op_t'(held_word[OPCODE_MSB:OPCODE_LSB]);
  assign dec_rd  = held_word[RD_MSB:RD_LSB];
  assign dec_rs  = held_word[RS_MSB:RS_LSB];
  assign dec_rt  = held_word[RT_MSB:RT_LSB];
  assign dec_imm = held_word[IMM_WIDTH-1:0];

endmodule

// ==== hdl/issue_queue.sv ====
`timescale 1ns/1ps

module issue_queue
  import core_pkg::*;
#(
  parameter int IQ_DEPTH  = 4,
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         alloc,
  input  op_t                          dec_op,
  input  logic [REG_ADDR_WIDTH-1:0]    dec_rs,
  input  logic [REG_ADDR_WIDTH-1:0]    dec_rt,
  input  logic [IMM_WIDTH-1:0]         dec_imm,
  input  logic [$clog2(ROB_DEPTH)-1:0] alloc_slot,
  input  logic                         pop,
  output logic                         iq_full,
  output logic                         iq_empty,
  output op_t                          iq_op,
  output logic [REG_ADDR_WIDTH-1:0]    iq_rs,
  output logic [REG_ADDR_WIDTH-1:0]    iq_rt,
  output logic [IMM_WIDTH-1:0]         iq_imm,
  output logic [$clog2(ROB_DEPTH)-1:0] iq_slot
);

  localparam int PTR_W  = $clog2(IQ_DEPTH);
  localparam int CNT_W  = $clog2(IQ_DEPTH + 1);
  localparam int SLOT_W = $clog2(ROB_DEPTH);

  op_t                       op_mem   [IQ_DEPTH];
  logic [REG_ADDR_WIDTH-1:0] rs_mem   [IQ_DEPTH];
  logic [REG_ADDR_WIDTH-1:0] rt_mem   [IQ_DEPTH];
  logic [IMM_WIDTH-1:0]      imm_mem  [IQ_DEPTH];
  logic [SLOT_W-1:0]         slot_mem [IQ_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [CNT_W-1:0] count;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(IQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (alloc) begin
        tail <= next_ptr(tail);
      end
      if (pop) begin
        head <= next_ptr(head);
      end
      count <= count + CNT_W'(alloc) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      op_mem[tail]   <= dec_op;
      rs_mem[tail]   <= dec_rs;
      rt_mem[tail]   <= dec_rt;
      imm_mem[tail]  <= dec_imm;
      slot_mem[tail] <= alloc_slot;
    end
  end

  assign iq_full  = (count == CNT_W'(IQ_DEPTH));
  assign iq_empty = (count == '0);
  assign iq_op    = op_mem[head];
  assign iq_rs    = rs_mem[head];
  assign iq_rt    = rt_mem[head];
  assign iq_imm   = imm_mem[head];
  assign iq_slot  = slot_mem[head];

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage
  import core_pkg::*;
#(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         iq_empty,
  input  op_t                          iq_op,
  input  logic [REG_ADDR_WIDTH-1:0]    iq_rs,
  input  logic [REG_ADDR_WIDTH-1:0]    iq_rt,
  input  logic [IMM_WIDTH-1:0]         iq_imm,
  input  logic [$clog2(ROB_DEPTH)-1:0] iq_slot,
  output logic                         pop,
  output logic [$clog2(ROB_DEPTH)-1:0] query_slot,
  output logic [REG_ADDR_WIDTH-1:0]    query_a_reg,
  output logic [REG_ADDR_WIDTH-1:0]    query_b_reg,
  input  logic                         a_hit,
  input  logic                         a_pending,
  input  logic [DATA_WIDTH-1:0]        a_value,
  input  logic                         b_hit,
  input  logic                         b_pending,
  input  logic [DATA_WIDTH-1:0]        b_value,
  output logic [REG_ADDR_WIDTH-1:0]    rf_a_addr,
  output logic [REG_ADDR_WIDTH-1:0]    rf_b_addr,
  input  logic [DATA_WIDTH-1:0]        rf_a_data,
  input  logic [DATA_WIDTH-1:0]        rf_b_data,
  output logic                         alu_go,
  output logic                         mul_go,
  output op_t                          ex_op,
  output logic [DATA_WIDTH-1:0]        ex_a,
  output logic [DATA_WIDTH-1:0]        ex_b,
  output logic [IMM_WIDTH-1:0]         ex_imm,
  output logic [$clog2(ROB_DEPTH)-1:0] ex_slot
);

  logic dispatch;

  // Lookups for the head entry alone keep issue in order
  assign query_slot  = iq_slot;
  assign query_a_reg = iq_rs;
  assign query_b_reg = iq_rt;
  assign rf_a_addr   = iq_rs;
  assign rf_b_addr   = iq_rt;

  // In-flight producer wins over the architectural value
  assign ex_a = a_hit ? a_value : rf_a_data;
  assign ex_b = b_hit ? b_value : rf_b_data;

  assign dispatch = !iq_empty && !a_pending && !b_pending;
  assign pop      = dispatch;
  assign mul_go   = dispatch && (iq_op == OP_MUL);
  assign alu_go   = dispatch && (iq_op != OP_MUL);

  assign ex_op   = iq_op;
  assign ex_imm  = iq_imm;
  assign ex_slot = iq_slot;

endmodule

// ==== hdl/exec_units.sv ====
`timescale 1ns/1ps

module exec_units
  import core_pkg::*;
#(
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         alu_go,
  input  logic                         mul_go,
  input  op_t                          ex_op,
  input  logic [DATA_WIDTH-1:0]        ex_a,
  input  logic [DATA_WIDTH-1:0]        ex_b,
  input  logic [IMM_WIDTH-1:0]         ex_imm,
  input  logic [$clog2(ROB_DEPTH)-1:0] ex_slot,
  output logic                         alu_wr_valid,
  output logic [$clog2(ROB_DEPTH)-1:0] alu_wr_slot,
  output logic [DATA_WIDTH-1:0]        alu_wr_data,
  output logic                         mul_wr_valid,
  output logic [$clog2(ROB_DEPTH)-1:0] mul_wr_slot,
  output logic [DATA_WIDTH-1:0]        mul_wr_data
);

  localparam int SLOT_W = $clog2(ROB_DEPTH);

  logic [DATA_WIDTH-1:0]  alu_result;
  logic [MUL_LATENCY-1:0] mul_valid;
  logic [SLOT_W-1:0]      mul_slot [MUL_LATENCY];
  logic [DATA_WIDTH-1:0]  mul_prod [MUL_LATENCY];

  always_comb begin
    case (ex_op)
      OP_SUB:  alu_result = ex_a - ex_b;
      OP_AND:  alu_result = ex_a & ex_b;
      OP_OR:   alu_result = ex_a | ex_b;
      OP_XOR:  alu_result = ex_a ^ ex_b;
      OP_SLT:  alu_result = {{(DATA_WIDTH-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
      OP_LI:   alu_result = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, ex_imm};
      default: alu_result = ex_a + ex_b;
    endcase
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      alu_wr_valid <= 1'b0;
    end else begin
      alu_wr_valid <= alu_go;
    end
  end

  always_ff @(posedge clock) begin
    alu_wr_slot <= ex_slot;
    alu_wr_data <= alu_result;
  end

  // Multiplier pipeline keeps the low half of the product
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      mul_valid <= '0;
    end else begin
      mul_valid[0] <= mul_go;
      for (int i = 1; i < MUL_LATENCY; i++) begin
        mul_valid[i] <= mul_valid[i-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    mul_slot[0] <= ex_slot;
    mul_prod[0] <= ex_a * ex_b;
    for (int i = 1; i < MUL_LATENCY; i++) begin
      mul_slot[i] <= mul_slot[i-1];
      mul_prod[i] <= mul_prod[i-1];
    end
  end

  assign mul_wr_valid = mul_valid[MUL_LATENCY-1];
  assign mul_wr_slot  = mul_slot[MUL_LATENCY-1];
  assign mul_wr_data  = mul_prod[MUL_LATENCY-1];

endmodule

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps

module reorder_buffer
  import core_pkg::*;
#(
  parameter int ROB_DEPTH = 8
) (
  input  logic                         clock,
  input  logic                         rst_n,
  input  logic                         alloc,
  input  logic [REG_ADDR_WIDTH-1:0]    dec_rd,
  output logic [$clog2(ROB_DEPTH)-1:0] alloc_slot,
  output logic                         rob_full,
  input  logic                         alu_wr_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0] alu_wr_slot,
  input  logic [DATA_WIDTH-1:0]        alu_wr_data,
  input  logic                         mul_wr_valid,
  input  logic [$clog2(ROB_DEPTH)-1:0] mul_wr_slot,
  input  logic [DATA_WIDTH-1:0]        mul_wr_data,
  input  logic [$clog2(ROB_DEPTH)-1:0] query_slot,
  input  logic [REG_ADDR_WIDTH-1:0]    query_a_reg,
  input  logic [REG_ADDR_WIDTH-1:0]    query_b_reg,
  output logic                         a_hit,
  output logic                         a_pending,
  output logic [DATA_WIDTH-1:0]        a_value,
  output logic                         b_hit,
  output logic                         b_pending,
  output logic [DATA_WIDTH-1:0]        b_value,
  output logic                         retire_valid,
  output logic [REG_ADDR_WIDTH-1:0]    retire_reg,
  output logic [DATA_WIDTH-1:0]        retire_data
);

  localparam int SLOT_W = $clog2(ROB_DEPTH);
  localparam int CNT_W  = $clog2(ROB_DEPTH + 1);

  logic [ROB_DEPTH-1:0]      busy;
  logic [ROB_DEPTH-1:0]      done;
  logic [REG_ADDR_WIDTH-1:0] dest  [ROB_DEPTH];
  logic [DATA_WIDTH-1:0]     value [ROB_DEPTH];

  logic [SLOT_W-1:0] head;
  logic [SLOT_W-1:0] tail;
  logic [CNT_W-1:0]  count;

  logic [REG_ADDR_WIDTH-1:0] src_reg [2];
  logic                      src_hit [2];
  logic                      src_pend [2];
  logic [DATA_WIDTH-1:0]     src_val [2];

  function automatic logic [SLOT_W-1:0] next_ptr(input logic [SLOT_W-1:0] ptr);
    return (ptr == SLOT_W'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign alloc_slot   = tail;
  assign rob_full     = (count == CNT_W'(ROB_DEPTH));
  assign retire_valid = busy[head] && done[head];
  assign retire_reg   = dest[head];
  assign retire_data  = value[head];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      busy  <= '0;
      done  <= '0;
    end else begin
      if (retire_valid) begin
        busy[head] <= 1'b0;
        head       <= next_ptr(head);
      end
      if (alloc) begin
        busy[tail] <= 1'b1;
        done[tail] <= 1'b0;
        tail       <= next_ptr(tail);
      end
      if (alu_wr_valid) begin
        done[alu_wr_slot] <= 1'b1;
      end
      if (mul_wr_valid) begin
        done[mul_wr_slot] <= 1'b1;
      end
      count <= count + CNT_W'(alloc) - CNT_W'(retire_valid);
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      dest[tail] <= dec_rd;
    end
    if (alu_wr_valid) begin
      value[alu_wr_slot] <= alu_wr_data;
    end
    if (mul_wr_valid) begin
      value[mul_wr_slot] <= mul_wr_data;
    end
  end

  assign src_reg[0] = query_a_reg;
  assign src_reg[1] = query_b_reg;

  // Scan from head to the entry before query_slot so the youngest match wins
  // A result written this cycle has no done bit yet and reads as pending
  always_comb begin
    int older;
    int idx;
    older = (int'(query_slot) - int'(head) + ROB_DEPTH) % ROB_DEPTH;
    for (int p = 0; p < 2; p++) begin
      src_hit[p]  = 1'b0;
      src_pend[p] = 1'b0;
      src_val[p]  = '0;
      for (int i = 0; i < ROB_DEPTH; i++) begin
        idx = (int'(head) + i) % ROB_DEPTH;
        if (i < older && busy[idx] && dest[idx] == src_reg[p] && src_reg[p] != '0) begin
          src_hit[p]  = 1'b1;
          src_pend[p] = !done[idx];
          src_val[p]  = value[idx];
        end
      end
    end
  end

  assign a_hit     = src_hit[0];
  assign a_pending = src_pend[0];
  assign a_value   = src_val[0];
  assign b_hit     = src_hit[1];
  assign b_pending = src_pend[1];
  assign b_value   = src_val[1];

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/1ps

module reg_file
  import core_pkg::*;
(
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic [REG_ADDR_WIDTH-1:0] rf_a_addr,
  input  logic [REG_ADDR_WIDTH-1:0] rf_b_addr,
  output logic [DATA_WIDTH-1:0]     rf_a_data,
  output logic [DATA_WIDTH-1:0]     rf_b_data,
  input  logic                      retire_valid,
  input  logic [REG_ADDR_WIDTH-1:0] retire_reg,
  input  logic [DATA_WIDTH-1:0]     retire_data
);

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (retire_valid && retire_reg != '0) begin
      regs[retire_reg] <= retire_data;
    end
  end

  // r0 is hardwired to zero
  assign rf_a_data = (rf_a_addr == '0) ? '0 : regs[rf_a_addr];
  assign rf_b_data = (rf_b_addr == '0) ? '0 : regs[rf_b_addr];

endmodule

// ==== hdl/ooo_core.sv ====
`timescale 1ns/1ps

module ooo_core
  import core_pkg::*;
#(
  parameter int IQ_DEPTH    = 4,
  parameter int ROB_DEPTH   = 8,
  parameter int MUL_LATENCY = 3
) (
  input  logic                      clock,
  input  logic                      rst_n,
  input  logic                      inst_valid,
  input  logic [OPCODE_MSB:0]       inst_word,
  output logic                      stall,
  output logic                      retire_valid,
  output logic [REG_ADDR_WIDTH-1:0] retire_reg,
  output logic [DATA_WIDTH-1:0]     retire_data
);

  localparam int SLOT_W = $clog2(ROB_DEPTH);

  logic                      alloc;
  op_t                       dec_op;
  logic [REG_ADDR_WIDTH-1:0] dec_rd;
  logic [REG_ADDR_WIDTH-1:0] dec_rs;
  logic [REG_ADDR_WIDTH-1:0] dec_rt;
  logic [IMM_WIDTH-1:0]      dec_imm;
  logic [SLOT_W-1:0]         alloc_slot;
  logic                      rob_full;

  logic                      iq_full;
  logic                      iq_empty;
  op_t                       iq_op;
  logic [REG_ADDR_WIDTH-1:0] iq_rs;
  logic [REG_ADDR_WIDTH-1:0] iq_rt;
  logic [IMM_WIDTH-1:0]      iq_imm;
  logic [SLOT_W-1:0]         iq_slot;
  logic                      pop;

  logic [SLOT_W-1:0]         query_slot;
  logic [REG_ADDR_WIDTH-1:0] query_a_reg;
  logic [REG_ADDR_WIDTH-1:0] query_b_reg;
  logic                      a_hit;
  logic                      a_pending;
  logic [DATA_WIDTH-1:0]     a_value;
  logic                      b_hit;
  logic                      b_pending;
  logic [DATA_WIDTH-1:0]     b_value;

  logic [REG_ADDR_WIDTH-1:0] rf_a_addr;
  logic [REG_ADDR_WIDTH-1:0] rf_b_addr;
  logic [DATA_WIDTH-1:0]     rf_a_data;
  logic [DATA_WIDTH-1:0]     rf_b_data;

  logic                      alu_go;
  logic                      mul_go;
  op_t                       ex_op;
  logic [DATA_WIDTH-1:0]     ex_a;
  logic [DATA_WIDTH-1:0]     ex_b;
  logic [IMM_WIDTH-1:0]      ex_imm;
  logic [SLOT_W-1:0]         ex_slot;

  logic                      alu_wr_valid;
  logic [SLOT_W-1:0]         alu_wr_slot;
  logic [DATA_WIDTH-1:0]     alu_wr_data;
  logic                      mul_wr_valid;
  logic [SLOT_W-1:0]         mul_wr_slot;
  logic [DATA_WIDTH-1:0]     mul_wr_data;

  decode_stage decode_stage_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst_word  (inst_word),
    .iq_full    (iq_full),
    .rob_full   (rob_full),
    .stall      (stall),
    .alloc      (alloc),
    .dec_op     (dec_op),
    .dec_rd     (dec_rd),
    .dec_rs     (dec_rs),
    .dec_rt     (dec_rt),
    .dec_imm    (dec_imm)
  );

  issue_queue #(
    .IQ_DEPTH  (IQ_DEPTH),
    .ROB_DEPTH (ROB_DEPTH)
  ) issue_queue_inst (
    .clock      (clock),
    .rst_n      (rst_n),
    .alloc      (alloc),
    .dec_op     (dec_op),
    .dec_rs     (dec_rs),
    .dec_rt     (dec_rt),
    .dec_imm    (dec_imm),
    .alloc_slot (alloc_slot),
    .pop        (pop),
    .iq_full    (iq_full),
    .iq_empty   (iq_empty),
    .iq_op      (iq_op),
    .iq_rs      (iq_rs),
    .iq_rt      (iq_rt),
    .iq_imm     (iq_imm),
    .iq_slot    (iq_slot)
  );

  issue_stage #(
    .ROB_DEPTH (ROB_DEPTH)
  ) issue_stage_inst (
    .iq_empty    (iq_empty),
    .iq_op       (iq_op),
    .iq_rs       (iq_rs),
    .iq_rt       (iq_rt),
    .iq_imm      (iq_imm),
    .iq_slot     (iq_slot),
    .pop         (pop),
    .query_slot  (query_slot),
    .query_a_reg (query_a_reg),
    .query_b_reg (query_b_reg),
    .a_hit       (a_hit),
    .a_pending   (a_pending),
    .a_value     (a_value),
    .b_hit       (b_hit),
    .b_pending   (b_pending),
    .b_value     (b_value),
    .rf_a_addr   (rf_a_addr),
    .rf_b_addr   (rf_b_addr),
    .rf_a_data   (rf_a_data),
    .rf_b_data   (rf_b_data),
    .alu_go      (alu_go),
    .mul_go      (mul_go),
    .ex_op       (ex_op),
    .ex_a        (ex_a),
    .ex_b        (ex_b),
    .ex_imm      (ex_imm),
    .ex_slot     (ex_slot)
  );

  exec_units #(
    .ROB_DEPTH   (ROB_DEPTH),
    .MUL_LATENCY (MUL_LATENCY)
  ) exec_units_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .alu_go       (alu_go),
    .mul_go       (mul_go),
    .ex_op        (ex_op),
    .ex_a         (ex_a),
    .ex_b         (ex_b),
    .ex_imm       (ex_imm),
    .ex_slot      (ex_slot),
    .alu_wr_valid (alu_wr_valid),
    .alu_wr_slot  (alu_wr_slot),
    .alu_wr_data  (alu_wr_data),
    .mul_wr_valid (mul_wr_valid),
    .mul_wr_slot  (mul_wr_slot),
    .mul_wr_data  (mul_wr_data)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH)
  ) reorder_buffer_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .alloc        (alloc),
    .dec_rd       (dec_rd),
    .alloc_slot   (alloc_slot),
    .rob_full     (rob_full),
    .alu_wr_valid (alu_wr_valid),
    .alu_wr_slot  (alu_wr_slot),
    .alu_wr_data  (alu_wr_data),
    .mul_wr_valid (mul_wr_valid),
    .mul_wr_slot  (mul_wr_slot),
    .mul_wr_data  (mul_wr_data),
    .query_slot   (query_slot),
    .query_a_reg  (query_a_reg),
    .query_b_reg  (query_b_reg),
    .a_hit        (a_hit),
    .a_pending    (a_pending),
    .a_value      (a_value),
    .b_hit        (b_hit),
    .b_pending    (b_pending),
    .b_value      (b_value),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

  reg_file reg_file_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .rf_a_addr    (rf_a_addr),
    .rf_b_addr    (rf_b_addr),
    .rf_a_data    (rf_a_data),
    .rf_b_data    (rf_b_data),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

endmodule

// ==== dv/tb_ooo_core.sv ====
`timescale 1ns/1ps

module tb_ooo_core
  import core_pkg::*;
;

  localparam int NUM_INSTS   = 400;
  localparam int STALL_LIMIT = 200;
  localparam int STIM_LIMIT  = 20000;
  localparam int DRAIN_LIMIT = 1000;

  logic                      clock;
  logic                      rst_n;
  logic                      inst_valid;
  logic [31:0]               inst_word;
  logic                      stall;
  logic                      retire_valid;
  logic [REG_ADDR_WIDTH-1:0] retire_reg;
  logic [DATA_WIDTH-1:0]     retire_data;

  logic [15:0]               lfsr;
  logic [REG_ADDR_WIDTH-1:0] prev_rd;
  logic                      word_taken;
  logic                      stall_seen;
  int                        post_reset;
  int                        mismatches;
  int                        other_errors;

  logic [DATA_WIDTH-1:0]     model_regs [NUM_REGS];
  logic [REG_ADDR_WIDTH-1:0] exp_regs [$];
  logic [DATA_WIDTH-1:0]     exp_data [$];

  ooo_core ooo_core_inst (
    .clock        (clock),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .inst_word    (inst_word),
    .stall        (stall),
    .retire_valid (retire_valid),
    .retire_reg   (retire_reg),
    .retire_data  (retire_data)
  );

  always #2 clock = ~clock;

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return bits;
  endfunction

  // Phases of 50 words cycle through mixed ops, multiply chains, mixed ops and r0 writes
  function automatic logic [31:0] make_word(input int idx);
    logic [31:0]               word;
    logic [3:0]                op;
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [REG_ADDR_WIDTH-1:0] rs;
    logic [REG_ADDR_WIDTH-1:0] rt;
    int                        phase;
    phase = (idx / 50) % 4;
    op = 4'(take_bits(3));
    if (phase == 1 && take_bits(2) != 0) begin
      op = 4'(OP_MUL);
    end
    if (phase == 0 && take_bits(3) == 0) begin
      op = op | 4'h8;
    end
    rd = REG_ADDR_WIDTH'(take_bits(3));
    rs = REG_ADDR_WIDTH'(take_bits(3));
    rt = REG_ADDR_WIDTH'(take_bits(3));
    if (phase == 1) begin
      rs = prev_rd;
    end
    if (phase == 3 && take_bits(1) != 0) begin
      rd = '0;
    end
    prev_rd = rd;
    word = '0;
    word[IMM_WIDTH-1:0] = IMM_WIDTH'(take_bits(IMM_WIDTH));
    word[OPCODE_MSB:OPCODE_LSB] = op;
    word[RD_MSB:RD_LSB] = rd;
    word[RS_MSB:RS_LSB] = rs;
    if (op != 4'(OP_LI)) begin
      word[RT_MSB:RT_LSB] = rt;
    end
    return word;
  endfunction

  function automatic logic [DATA_WIDTH-1:0] expected_result(input logic [3:0] op,
      input logic [DATA_WIDTH-1:0] a, input logic [DATA_WIDTH-1:0] b,
      input logic [IMM_WIDTH-1:0] imm);
    case (op)
      4'(OP_SUB): return a - b;
      4'(OP_AND): return a & b;
      4'(OP_OR):  return a | b;
      4'(OP_XOR): return a ^ b;
      4'(OP_SLT): return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      4'(OP_MUL): return a * b;
      4'(OP_LI):  return {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, imm};
      default:    return a + b;
    endcase
  endfunction

  task automatic model_accept(input logic [31:0] word);
    logic [REG_ADDR_WIDTH-1:0] rd;
    logic [DATA_WIDTH-1:0]     result;
    rd = word[RD_MSB:RD_LSB];
    result = expected_result(word[OPCODE_MSB:OPCODE_LSB], model_regs[word[RS_MSB:RS_LSB]],
                             model_regs[word[RT_MSB:RT_LSB]], word[IMM_WIDTH-1:0]);
    if (rd != '0) begin
      model_regs[rd] = result;
    end
    exp_regs.push_back(rd);
    exp_data.push_back(result);
  endtask

  task automatic check_retire();
    logic [REG_ADDR_WIDTH-1:0] want_reg;
    logic [DATA_WIDTH-1:0]     want_data;
    assert (exp_regs.size() != 0) else begin
      other_errors++;
      $display("Retirement seen with no instruction outstanding (reg %0d)", retire_reg);
    end
    if (exp_regs.size() != 0) begin
      want_reg = exp_regs.pop_front();
      want_data = exp_data.pop_front();
      assert (retire_reg == want_reg) else begin
        mismatches++;
        $display("Mismatch retire_reg: got %h expected %h", retire_reg, want_reg);
      end
      assert (retire_data == want_data) else begin
        mismatches++;
        $display("Mismatch retire_data: got %h expected %h", retire_data, want_data);
      end
    end
  endtask

  // Outputs are stable mid-cycle and each sample stands for the next rising edge
  always @(negedge clock) begin
    word_taken = inst_valid && !stall;
    if (!rst_n || post_reset < 2) begin
      assert (!retire_valid && !stall) else begin
        other_errors++;
        $display("Retire or stall active during or just after reset");
      end
    end
    if (rst_n) begin
      post_reset++;
      if (stall) begin
        stall_seen = 1'b1;
      end
      if (word_taken) begin
        model_accept(inst_word);
      end
      if (retire_valid) begin
        check_retire();
      end
    end
  end

  initial begin
    int  gen;
    int  cycles;
    int  stall_run;
    bit  timed_out;
    clock = 1'b0;
    rst_n = 1'b0;
    inst_valid = 1'b0;
    inst_word = '0;
    lfsr = 16'd28;
    prev_rd = '0;
    word_taken = 1'b0;
    stall_seen = 1'b0;
    post_reset = 0;
    mismatches = 0;
    other_errors = 0;
    timed_out = 1'b0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    repeat (10) @(posedge clock);
    #0.5;
    rst_n = 1'b1;

    gen = 0;
    cycles = 0;
    stall_run = 0;
    while (gen < NUM_INSTS) begin
      @(posedge clock);
      #0.5;
      cycles++;
      if (inst_valid && word_taken) begin
        gen++;
      end
      if (!inst_valid || word_taken) begin
        if (gen < NUM_INSTS && ((gen / 50) % 4 == 1 || take_bits(2) != 0)) begin
          inst_word = make_word(gen);
          inst_valid = 1'b1;
        end else begin
          inst_valid = 1'b0;
        end
      end
      stall_run = stall ? stall_run + 1 : 0;
      if (stall_run > STALL_LIMIT || cycles > STIM_LIMIT) begin
        other_errors++;
        timed_out = 1'b1;
        $display("Timeout: core stopped accepting instructions after %0d words", gen);
        break;
      end
    end
    inst_valid = 1'b0;

    if (!timed_out) begin
      cycles = 0;
      while (exp_regs.size() != 0 && cycles < DRAIN_LIMIT) begin
        @(posedge clock);
        cycles++;
      end
      assert (exp_regs.size() == 0) else begin
        other_errors++;
        $display("Timeout: %0d instructions never retired", exp_regs.size());
      end
      // Quiet period catches retirements beyond the expected stream
      repeat (20) @(posedge clock);
    end

    assert (stall_seen) else begin
      other_errors++;
      $display("Stall never went high, so back-pressure was not exercised");
    end

    $display("Errors: %0d mismatches, %0d other failures", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/issue_queue.sv
hdl/issue_stage.sv
hdl/exec_units.sv
hdl/reorder_buffer.sv
hdl/reg_file.sv
hdl/ooo_core.sv
dv/tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - hdl/core_pkg.sv
  - hdl/decode_stage.sv
  - hdl/issue_queue.sv
  - hdl/issue_stage.sv
  - hdl/exec_units.sv
  - hdl/reorder_buffer.sv
  - hdl/reg_file.sv
  - hdl/ooo_core.sv
  - target: simulation
    files:
      - dv/tb_ooo_core.sv
